//--- Bender.yml
package:
  name: rename_core

sources:
  - files:
      - hw/rename_pkg.sv
      - hw/rename_ifs.sv
      - hw/issue_unit.sv
      - hw/register_file.sv
      - hw/reorder_buffer.sv
      - hw/rename_core.sv
  - target: test
    files:
      - dv/rename_core_checker.sv
      - dv/rename_core_tb.sv

//--- dv/rename_core_checker.sv
`timescale 1ns/100ps
`default_nettype none

module rename_core_checker
	import rename_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [ROB_WIDTH:0] head,
	input logic [ROB_WIDTH:0] tail,
	input logic commit,
	input logic done_valid,
	input rob_tag_t done_tag,
	input logic full,
	input logic issue
);
	// Equal pointers including the wrap bit mean empty.
	a_no_commit_when_empty: assert property (@(posedge clk) disable iff (reset)
		commit |-> head != tail)
		else $error("Commit while the reorder buffer is empty.");

	// Head completed on the last edge, or done earlier behind the entry retired then.
	a_commit_needs_done: assert property (@(posedge clk) disable iff (reset)
		commit |-> $past(commit) ||
			($past(done_valid) && $past(done_tag) == head[ROB_WIDTH-1:0]))
		else $error("Commit of a head entry that is not done.");

	a_full_blocks_issue: assert property (@(posedge clk) disable iff (reset)
		full |-> !issue)
		else $error("Issue while the reorder buffer is full.");

endmodule

bind reorder_buffer rename_core_checker rename_core_checker_inst (
	.clk(clk),
	.reset(reset),
	.head(head),
	.tail(tail),
	.commit(cm.commit),
	.done_valid(done_valid),
	.done_tag(done_tag),
	.full(full),
	.issue(inst.issue)
);

`default_nettype wire

//--- dv/rename_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rename_core_tb
	import rename_pkg::*;
();
	localparam int NUM_COMMITS = 400;
	localparam int MAX_CYCLES = 6000;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	arch_num_t in_r0;
	arch_num_t in_r1;
	arch_num_t in_r2;
	logic done_valid;
	rob_tag_t done_tag;
	word_t done_data;
	logic out_valid;
	rob_tag_t out_tag;
	cdb_t out_src1;
	cdb_t out_src2;
	logic cm_valid;
	arch_num_t cm_arch_num;
	rob_tag_t cm_tag;
	word_t cm_data;

	int seed = 32'h5f44;
	int cycle;
	int commit_count;

	// Reference model state.
	cdb_t model_regs [NUM_REGS];
	rob_tag_t inflight [$]; // Allocation order.
	arch_num_t rob_dest [ROB_DEPTH];
	word_t rob_data [ROB_DEPTH];
	logic rob_done [ROB_DEPTH];
	rob_tag_t next_tag;
	logic pend_valid; // Issued output expected this cycle.
	rob_tag_t pend_tag;
	cdb_t pend_src1;
	cdb_t pend_src2;

	rename_core rename_core_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_run();
		$display("*** FAILED ***");
		$fatal(1, "Run aborted.");
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_tag(rob_tag_t got, rob_tag_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: out_tag is %0d, expected %0d", $time, got, exp);
			stop_run();
		end
	endtask

	task automatic check_operand(string name, cdb_t got, cdb_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is v=%b t=%0d d=%h, expected v=%b t=%0d d=%h", $time,
				name, got.valid, got.tag, got.data, exp.valid, exp.tag, exp.data);
			stop_run();
		end
	endtask

	task automatic check_commit(arch_num_t got_arch, rob_tag_t got_tag, word_t got_data,
			arch_num_t exp_arch, rob_tag_t exp_tag, word_t exp_data);
		if (got_arch !== exp_arch || got_tag !== exp_tag || got_data !== exp_data) begin
			$display("ERROR at %0t: commit r%0d t%0d %h, expected r%0d t%0d %h", $time,
				got_arch, got_tag, got_data, exp_arch, exp_tag, exp_data);
			stop_run();
		end
	endtask

	// Called on a rising edge, values apply at the next one.
	task automatic drive_inputs();
		rob_tag_t cand [$];
		logic hold;
		hold = (cycle % 80) >= 50; // Starve completions so the buffer fills.
		foreach (inflight[k]) begin
			if (!rob_done[inflight[k]]) begin
				cand.push_back(inflight[k]);
			end
		end
		in_valid <= ($random(seed) & 3) != 0;
		in_r0 <= arch_num_t'($random(seed));
		in_r1 <= arch_num_t'($random(seed));
		in_r2 <= arch_num_t'($random(seed));
		if (!hold && cand.size() > 0 && ($random(seed) & 1)) begin
			done_valid <= 1'b1;
			done_tag <= cand[$unsigned($random(seed)) % cand.size()]; // Out of order.
			done_data <= $random(seed);
		end else begin
			done_valid <= 1'b0;
		end
	endtask

	// Called between edges: check outputs, then advance the model past the next edge.
	task automatic check_and_step();
		cdb_t old_regs [NUM_REGS];
		logic exp_ready;
		logic exp_commit;
		logic accept;
		rob_tag_t head;
		head = inflight.size() > 0 ? inflight[0] : '0;
		exp_ready = inflight.size() < ROB_DEPTH;
		exp_commit = inflight.size() > 0 && rob_done[head];
		check_flag("in_ready", in_ready, exp_ready);
		check_flag("out_valid", out_valid, pend_valid);
		if (pend_valid) begin
			check_tag(out_tag, pend_tag);
			check_operand("out_src1", out_src1, pend_src1);
			check_operand("out_src2", out_src2, pend_src2);
		end
		check_flag("cm_valid", cm_valid, exp_commit);
		if (exp_commit) begin
			check_commit(cm_arch_num, cm_tag, cm_data, rob_dest[head], head, rob_data[head]);
		end

		old_regs = model_regs;
		accept = in_valid && exp_ready;
		pend_valid = accept;
		if (accept) begin
			pend_tag = next_tag;
			pend_src1 = old_regs[in_r1];
			pend_src2 = old_regs[in_r2];
		end
		if (exp_commit) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				if (!(accept && in_r0 == arch_num_t'(i)) && old_regs[i].tag == head) begin
					model_regs[i].valid = 1'b1;
				end
			end
			if (!old_regs[rob_dest[head]].valid) begin
				model_regs[rob_dest[head]].data = rob_data[head];
			end
			void'(inflight.pop_front());
			commit_count++;
		end
		if (accept) begin
			model_regs[in_r0].valid = 1'b0; // Rename wins over a same-edge wake.
			model_regs[in_r0].tag = next_tag;
			rob_dest[next_tag] = in_r0;
			rob_done[next_tag] = 1'b0;
			inflight.push_back(next_tag);
			next_tag++;
		end
		if (done_valid) begin
			rob_done[done_tag] = 1'b1;
			rob_data[done_tag] = done_data;
		end
	endtask

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_r0 = '0;
		in_r1 = '0;
		in_r2 = '0;
		done_valid = 1'b0;
		done_tag = '0;
		done_data = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			model_regs[i] = '{valid: 1'b1, tag: '0, data: '0};
		end
		next_tag = '0;
		pend_valid = 1'b0;
		cycle = 0;
		commit_count = 0;

		repeat (10) @(posedge clk);
		reset <= 1'b0;
		while (commit_count < NUM_COMMITS && cycle < MAX_CYCLES) begin
			drive_inputs();
			@(negedge clk);
			check_and_step();
			@(posedge clk);
			cycle++;
		end

		if (commit_count >= NUM_COMMITS) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("Timeout: the design stopped committing after %0d cycles.", cycle);
			stop_run();
		end
	end

endmodule

`default_nettype wire

//--- hw/issue_unit.sv
`timescale 1ns/100ps
`default_nettype none

module issue_unit
	import rename_pkg::*;
(
	input logic clk,
	input logic reset,

	// Decoded instruction in.
	input logic in_valid,
	output logic in_ready,
	input arch_num_t in_r0,
	input arch_num_t in_r1,
	input arch_num_t in_r2,

	// Source operands from the register file.
	input cdb_t src1,
	input cdb_t src2,

	// Issued instruction out.
	output logic out_valid,
	output rob_tag_t out_tag,
	output cdb_t out_src1,
	output cdb_t out_src2,

	inst_if.issuer inst
);
	logic accept;

	// Stall while every reorder-buffer entry is in flight.
	assign in_ready = !inst.full;
	assign accept = in_valid && in_ready;

	assign inst.issue = accept;
	assign inst.r0 = in_r0;
	assign inst.r1 = in_r1; // Read port 1 address.
	assign inst.r2 = in_r2; // Read port 2 address.

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= accept; // Single cycle, never held.
		end
	end

	// Operands are sampled before the rename of r0 lands,
	// so an instruction reading its own destination sees the old value.
	always_ff @(posedge clk) begin
		if (accept) begin
			out_tag <= inst.tag;
			out_src1 <= src1;
			out_src2 <= src2;
		end
	end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file
	import rename_pkg::*;
(
	input logic clk,
	input logic reset,

	inst_if.reader inst,
	commit_if.writer cm,

	output cdb_t src1,
	output cdb_t src2
);
	localparam cdb_t REG_INIT = '{
		valid: 1'b1,
		tag: '0,
		data: '0
	};

	cdb_t regs [NUM_REGS];

	// Combinational read ports.
	assign src1 = regs[inst.r1];
	assign src2 = regs[inst.r2];

	for (genvar i = 0; i < NUM_REGS; i++) begin : g_reg
		logic rename;
		logic wake;
		logic fill;

		assign rename = inst.issue && inst.r0 == arch_num_t'(i);

		// Any register still waiting on the retiring tag becomes final.
		assign wake = cm.commit && regs[i].tag == cm.tag;

		// Data goes to the committed destination unless it is already final.
		assign fill = cm.commit && !regs[i].valid && cm.arch_num == arch_num_t'(i);

		always_ff @(posedge clk) begin
			if (reset) begin
				regs[i] <= REG_INIT;
			end else begin
				if (rename) begin
					regs[i].valid <= 1'b0; // Issue wins over commit.
					regs[i].tag <= inst.tag;
				end else if (wake) begin
					regs[i].valid <= 1'b1;
				end

				if (fill) begin
					regs[i].data <= cm.data;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/rename_core.sv
`timescale 1ns/100ps
`default_nettype none

module rename_core
	import rename_pkg::*;
(
	input logic clk,
	input logic reset,

	// Instruction input.
	input logic in_valid,
	output logic in_ready,
	input arch_num_t in_r0,
	input arch_num_t in_r1,
	input arch_num_t in_r2,

	// Completion input.
	input logic done_valid,
	input rob_tag_t done_tag,
	input word_t done_data,

	// Issued output.
	output logic out_valid,
	output rob_tag_t out_tag,
	output cdb_t out_src1,
	output cdb_t out_src2,

	// Commit output.
	output logic cm_valid,
	output arch_num_t cm_arch_num,
	output rob_tag_t cm_tag,
	output word_t cm_data
);
	inst_if inst ();
	commit_if cm ();

	cdb_t rf_src1;
	cdb_t rf_src2;

	issue_unit issue_unit_inst (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_r0(in_r0),
		.in_r1(in_r1),
		.in_r2(in_r2),
		.src1(rf_src1),
		.src2(rf_src2),
		.out_valid(out_valid),
		.out_tag(out_tag),
		.out_src1(out_src1),
		.out_src2(out_src2),
		.inst(inst)
	);

	register_file register_file_inst (
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.cm(cm),
		.src1(rf_src1),
		.src2(rf_src2)
	);

	reorder_buffer reorder_buffer_inst (
		.clk(clk),
		.reset(reset),
		.done_valid(done_valid),
		.done_tag(done_tag),
		.done_data(done_data),
		.inst(inst),
		.cm(cm)
	);

	// Commit port mirrored to the outside.
	assign cm_valid = cm.commit;
	assign cm_arch_num = cm.arch_num;
	assign cm_tag = cm.tag;
	assign cm_data = cm.data;

endmodule

`default_nettype wire

//--- hw/rename_ifs.sv
`timescale 1ns/100ps
`default_nettype none

// Accepted instruction, issue unit to register file and reorder buffer.
interface inst_if
	import rename_pkg::*;
();
	logic issue; // One cycle per accepted instruction.
	arch_num_t r0; // Destination.
	arch_num_t r1;
	arch_num_t r2;
	rob_tag_t tag; // Tail of the reorder buffer.
	logic full;

	modport issuer (
		output issue,
		output r0,
		output r1,
		output r2,
		input tag,
		input full
	);

	modport reader (
		input issue,
		input r0,
		input r1,
		input r2,
		input tag
	);

	modport allocator (
		input issue,
		input r0,
		output tag,
		output full
	);
endinterface

// In-order retirement, reorder buffer to register file.
interface commit_if
	import rename_pkg::*;
();
	logic commit;
	arch_num_t arch_num;
	rob_tag_t tag;
	word_t data;

	modport retirer (
		output commit,
		output arch_num,
		output tag,
		output data
	);

	modport writer (
		input commit,
		input arch_num,
		input tag,
		input data
	);
endinterface

`default_nettype wire

//--- hw/rename_pkg.sv
`default_nettype none

package rename_pkg;

	// Register number and reorder-buffer tag widths.
	localparam int REG_WIDTH = 3;
	localparam int ROB_WIDTH = 3;
	localparam int WORD_WIDTH = 32;

	localparam int NUM_REGS = 2**REG_WIDTH;
	localparam int ROB_DEPTH = 2**ROB_WIDTH;

	typedef logic [REG_WIDTH-1:0] arch_num_t;
	typedef logic [ROB_WIDTH-1:0] rob_tag_t;
	typedef logic [WORD_WIDTH-1:0] word_t;

	// Operand record, 36 bits.
	typedef struct packed {
		logic valid;   // Data is final.
		rob_tag_t tag; // Pending writer when not valid.
		word_t data;
	} cdb_t;

endpackage

`default_nettype wire

//--- hw/reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer
	import rename_pkg::*;
(
	input logic clk,
	input logic reset,

	// Results from the execution units, by tag.
	input logic done_valid,
	input rob_tag_t done_tag,
	input word_t done_data,

	inst_if.allocator inst,
	commit_if.retirer cm
);
	// Pointers carry one wrap bit above the index.
	logic [ROB_WIDTH:0] head;
	logic [ROB_WIDTH:0] tail;
	rob_tag_t head_tag;
	rob_tag_t tail_tag;
	logic full;

	logic [ROB_DEPTH-1:0] occupied;
	logic [ROB_DEPTH-1:0] done;
	arch_num_t dest [ROB_DEPTH];
	word_t result [ROB_DEPTH];

	assign head_tag = head[ROB_WIDTH-1:0];
	assign tail_tag = tail[ROB_WIDTH-1:0];

	// Same index, opposite wrap bits.
	assign full = head[ROB_WIDTH] != tail[ROB_WIDTH] && head_tag == tail_tag;

	assign inst.full = full;
	assign inst.tag = tail_tag; // Next tag handed out.

	// Retire the head as soon as its result is in.
	assign cm.commit = occupied[head_tag] && done[head_tag];
	assign cm.arch_num = dest[head_tag];
	assign cm.tag = head_tag;
	assign cm.data = result[head_tag];

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			occupied <= '0;
			done <= '0;
		end else begin
			if (inst.issue) begin
				occupied[tail_tag] <= 1'b1;
				done[tail_tag] <= 1'b0;
				tail <= tail + 1'b1;
			end

			// Completions may arrive in any order.
			if (done_valid) begin
				done[done_tag] <= 1'b1;
			end

			if (cm.commit) begin
				occupied[head_tag] <= 1'b0;
				head <= head + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (inst.issue) begin
			dest[tail_tag] <= inst.r0;
		end
		if (done_valid) begin
			result[done_tag] <= done_data;
		end
	end

endmodule

`default_nettype wire

//--- vlog.f
hw/rename_pkg.sv
hw/rename_ifs.sv
hw/issue_unit.sv
hw/register_file.sv
hw/reorder_buffer.sv
hw/rename_core.sv
dv/rename_core_checker.sv
dv/rename_core_tb.sv
